// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = amul_tb
FILELIST = files.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator exits with a failing status on any $fatal or assertion error.
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+hdl
hdl/amul_pkg.sv
hdl/bw_mult_approx.sv
hdl/bw_mult_exact.sv
hdl/err_accum.sv
hdl/amul_wb_regs.sv
hdl/amul_top.sv
sim/amul_properties.sv
sim/amul_tb.sv

// ==== hdl/amul_config.svh ====
`ifndef AMUL_CONFIG_SVH
`define AMUL_CONFIG_SVH

// word addresses of the register block, as seen on the 3-bit adr bus.
// a write to the operand word launches a multiply.
`define AMUL_ADDR_OPERANDS 3'd0
`define AMUL_ADDR_MODE     3'd1
`define AMUL_ADDR_RESULT   3'd2
`define AMUL_ADDR_STATUS   3'd3
// a write of any value to the count word clears all statistics.
`define AMUL_ADDR_COUNT    3'd4
`define AMUL_ADDR_ERR_SUM  3'd5
`define AMUL_ADDR_ERR_MAX  3'd6

// width of the saturating error sum. wider sums read back their low word.
`define AMUL_ERR_SUM_W 32

`endif

// ==== hdl/amul_pkg.sv ====
package amul_pkg;

    // mode opcodes held in bits 1:0 of the MODE register.
    // code 2'b11 is reserved and behaves as op_exact.
    typedef enum logic [1:0] {
        op_exact   = 2'd0,
        op_approx  = 2'd1,
        op_measure = 2'd2
    } amul_mode_e;

    // one multiplier operand, two's complement.
    typedef logic signed [15:0] operand_t;

    // full product of two operands.
    typedef logic signed [31:0] product_t;

    // magnitude of the difference between two products.
    // the exact product never leaves +-2^30, so the gap stays below 2^32.
    typedef logic [31:0] abs_err_t;

endpackage

// ==== hdl/amul_top.sv ====
`timescale 1ns/1ps

module amul_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [2:0]  adr,
    input  logic [31:0] dat_w,
    input  logic [3:0]  sel,
    output logic [31:0] dat_r,
    output logic        ack
);
    import amul_pkg::*;

    operand_t    op_x;
    operand_t    op_y;
    product_t    prod_exact;
    product_t    prod_approx;
    product_t    s_exact;
    product_t    s_approx;
    logic        sample_valid;
    logic        stats_clear;
    logic [31:0] count;
    abs_err_t    err_sum;
    abs_err_t    err_max;

    amul_wb_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .sel          (sel),
        .dat_r        (dat_r),
        .ack          (ack),
        .op_x         (op_x),
        .op_y         (op_y),
        .prod_exact   (prod_exact),
        .prod_approx  (prod_approx),
        .sample_valid (sample_valid),
        .stats_clear  (stats_clear),
        .s_exact      (s_exact),
        .s_approx     (s_approx),
        .count        (count),
        .err_sum      (err_sum),
        .err_max      (err_max)
    );

    // both arrays see the same operands every cycle.
    bw_mult_exact u_mult_exact (
        .x (op_x),
        .y (op_y),
        .z (prod_exact)
    );

    bw_mult_approx u_mult_approx (
        .x (op_x),
        .y (op_y),
        .z (prod_approx)
    );

    err_accum u_err (
        .clk          (clk),
        .rst          (rst),
        .clear        (stats_clear),
        .sample_valid (sample_valid),
        .prod_exact   (s_exact),
        .prod_approx  (s_approx),
        .count        (count),
        .err_sum      (err_sum),
        .err_max      (err_max)
    );

endmodule

// ==== hdl/amul_wb_regs.sv ====
`timescale 1ns/1ps

`include "amul_config.svh"

module amul_wb_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  logic [2:0]         adr,
    input  logic [31:0]        dat_w,
    input  logic [3:0]         sel,
    output logic [31:0]        dat_r,
    output logic               ack,
    output amul_pkg::operand_t op_x,
    output amul_pkg::operand_t op_y,
    input  amul_pkg::product_t prod_exact,
    input  amul_pkg::product_t prod_approx,
    output logic               sample_valid,
    output logic               stats_clear,
    output amul_pkg::product_t s_exact,
    output amul_pkg::product_t s_approx,
    input  logic [31:0]        count,
    input  amul_pkg::abs_err_t err_sum,
    input  amul_pkg::abs_err_t err_max
);
    import amul_pkg::*;

    logic        req;
    logic        wr_en;
    logic        launch;
    logic        busy;
    amul_mode_e  mode_q;
    logic        v0;
    logic        v1;
    amul_mode_e  m0;
    amul_mode_e  m1;
    product_t    sel_prod;
    product_t    result;
    logic [31:0] rd_data;

    // a transfer is taken only while ack is low, so each one is acked once.
    assign req   = cyc & stb & ~ack;
    // writes with a partial byte select have no effect.
    assign wr_en = req & we & (sel == 4'hf);

    assign launch      = wr_en & (adr == `AMUL_ADDR_OPERANDS);
    assign stats_clear = wr_en & (adr == `AMUL_ADDR_COUNT);

    // stage 0 is the cycle after the operand write, stage 1 the one after that.
    assign busy         = v0 | v1;
    assign sample_valid = v1 & (m1 == op_measure);

    always_comb begin
        case (m0)
            op_approx, op_measure: sel_prod = prod_approx;
            default:               sel_prod = prod_exact;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack    <= 1'b0;
            mode_q <= op_exact;
            v0     <= 1'b0;
            v1     <= 1'b0;
            m0     <= op_exact;
            m1     <= op_exact;
        end else begin
            ack <= req;
            if (wr_en && adr == `AMUL_ADDR_MODE) begin
                mode_q <= amul_mode_e'(dat_w[1:0]);
            end
            v0 <= launch;
            v1 <= v0;
            // each stage keeps the mode that was current when its sample launched.
            if (launch) begin
                m0 <= mode_q;
            end
            if (v0) begin
                m1 <= m0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            op_x <= dat_w[15:0];
            op_y <= dat_w[31:16];
        end
        if (v0) begin
            result   <= sel_prod;
            s_exact  <= prod_exact;
            s_approx <= prod_approx;
        end
        if (req && !we) begin
            dat_r <= rd_data;
        end
    end

    always_comb begin
        case (adr)
            `AMUL_ADDR_MODE:    rd_data = {30'b0, mode_q};
            `AMUL_ADDR_RESULT:  rd_data = result;
            `AMUL_ADDR_STATUS:  rd_data = {31'b0, busy};
            `AMUL_ADDR_COUNT:   rd_data = count;
            `AMUL_ADDR_ERR_SUM: rd_data = err_sum;
            `AMUL_ADDR_ERR_MAX: rd_data = err_max;
            default:            rd_data = '0;
        endcase
    end

endmodule

// ==== hdl/bw_mult_approx.sv ====
`timescale 1ns/1ps

module bw_mult_approx (
    input  amul_pkg::operand_t x,
    input  amul_pkg::operand_t y,
    output amul_pkg::product_t z
);

    logic [15:0] pp [16];
    logic [20:0] np1;
    logic [20:0] np2;
    logic [20:0] np3;
    logic [20:0] np4;
    logic [31:0] acc;

    // baugh-wooley rows. rows 0 to 14 invert the sign-column term,
    // row 15 inverts the low terms instead.
    always_comb begin
        for (int i = 0; i < 15; i++) begin
            pp[i][14:0] = y[14:0] & {15{x[i]}};
            pp[i][15]   = ~(y[15] & x[i]);
        end
        pp[15][14:0] = ~(y[14:0] & {15{x[15]}});
        pp[15][15]   = y[15] & x[15];
    end

    // rows 0 to 5 are squeezed into four sparse terms.
    // most low columns are dropped and neighbouring rows are paired
    // with cheap xor, and, or gates instead of full adders.
    assign np1[0]     = pp[0][0];
    assign np1[1]     = pp[0][1] ^ pp[1][0];
    assign np1[2]     = pp[0][2] ^ pp[1][1];
    assign np1[3]     = 1'b0;
    assign np1[4]     = pp[2][1] & pp[3][0];
    assign np1[5]     = pp[0][4] & pp[1][3];
    assign np1[6]     = pp[2][4] ^ pp[3][3];
    assign np1[7]     = pp[0][7] ^ pp[1][6];
    assign np1[8]     = pp[4][4] ^ pp[5][3];
    assign np1[9]     = pp[0][9] ^ pp[1][8];
    assign np1[10]    = pp[2][8] ^ pp[3][7];
    assign np1[14:11] = 4'b0;
    assign np1[15]    = pp[0][14] & pp[1][13];
    assign np1[16]    = pp[2][14] | pp[3][13];
    // the sign term of row 1 is swamped by the correction one at bit 17.
    assign np1[17]    = 1'b1;
    assign np1[18]    = pp[2][15] & pp[3][14];
    assign np1[19]    = pp[4][14] & pp[5][13];
    assign np1[20]    = pp[4][15] & pp[5][14];

    assign np2 = {
        pp[5][15],
        pp[4][15] ^ pp[5][14],
        pp[3][15],
        pp[2][15] ^ pp[3][14],
        1'b0,
        pp[4][11] ^ pp[5][10],
        4'b0,
        pp[4][6] ^ pp[5][5],
        pp[4][5] ^ pp[5][4],
        9'b0
    };

    assign np3 = {
        2'b0,
        pp[4][13] | pp[5][12],
        pp[4][12] | pp[5][11],
        17'b0
    };

    assign np4 = {
        3'b0,
        pp[4][13] ^ pp[5][12],
        17'b0
    };

    // rows 6 to 15 go in whole. the sum wraps at 32 bits like the exact one.
    always_comb begin
        acc = {11'b0, np1} + {11'b0, np2} + {11'b0, np3} + {11'b0, np4};
        for (int i = 6; i < 16; i++) begin
            acc = acc + ({16'b0, pp[i]} << i);
        end
        // correction one that belongs to row 15.
        acc = acc + 32'h8000_0000;
    end

    assign z = acc;

endmodule

// ==== hdl/bw_mult_exact.sv ====
`timescale 1ns/1ps

module bw_mult_exact (
    input  amul_pkg::operand_t x,
    input  amul_pkg::operand_t y,
    output amul_pkg::product_t z
);

    logic [15:0] pp [16];
    logic [31:0] acc;

    // same rows as the approximate array, so any gap between the two
    // comes only from the pruned low rows.
    always_comb begin
        for (int i = 0; i < 15; i++) begin
            pp[i][14:0] = y[14:0] & {15{x[i]}};
            pp[i][15]   = ~(y[15] & x[i]);
        end
        pp[15][14:0] = ~(y[14:0] & {15{x[15]}});
        pp[15][15]   = y[15] & x[15];
    end

    // the correction ones at bits 16 and 31 turn the unsigned row sum
    // into the two's complement product, modulo 2^32.
    always_comb begin
        acc = 32'h8001_0000;
        for (int i = 0; i < 16; i++) begin
            acc = acc + ({16'b0, pp[i]} << i);
        end
    end

    assign z = acc;

endmodule

// ==== hdl/err_accum.sv ====
`timescale 1ns/1ps

`include "amul_config.svh"

module err_accum (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  logic               sample_valid,
    input  amul_pkg::product_t prod_exact,
    input  amul_pkg::product_t prod_approx,
    output logic [31:0]        count,
    output amul_pkg::abs_err_t err_sum,
    output amul_pkg::abs_err_t err_max
);
    import amul_pkg::*;

    localparam int SUM_W = `AMUL_ERR_SUM_W;

    logic [32:0]      diff;
    abs_err_t         abs_err;
    logic [SUM_W:0]   err_ext;
    logic [SUM_W:0]   sum_add;
    logic [SUM_W-1:0] sum_q;

    // one extra bit keeps the difference of two 32-bit products exact.
    assign diff = {prod_exact[31], prod_exact} - {prod_approx[31], prod_approx};

    // the magnitude always fits in 32 bits, so negating the low word is enough.
    assign abs_err = diff[32] ? (~diff[31:0] + 32'd1) : diff[31:0];

    assign err_ext = {{(SUM_W + 1 - 32){1'b0}}, abs_err};
    assign sum_add = {1'b0, sum_q} + err_ext;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            count   <= '0;
            sum_q   <= '0;
            err_max <= '0;
        end else if (sample_valid) begin
            count <= count + 32'd1;
            // the sum sticks at all ones once it overflows.
            if (sum_add[SUM_W]) begin
                sum_q <= '1;
            end else begin
                sum_q <= sum_add[SUM_W-1:0];
            end
            if (abs_err > err_max) begin
                err_max <= abs_err;
            end
        end
    end

    assign err_sum = sum_q[31:0];

endmodule

// ==== sim/amul_properties.sv ====
`timescale 1ns/1ps

module amul_properties (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic busy
);

    // every ack answers a transfer that was on the bus one cycle earlier.
    ack_follows_transfer: assert property (
        @(posedge clk) disable iff (rst) ack |-> $past(cyc && stb)
    ) else $error("ack raised without a transfer in the previous cycle");

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (rst) ack |=> !ack
    ) else $error("ack stayed high for more than one cycle");

    // the reset is synchronous, so both outputs clear one edge after rst is seen.
    reset_clears_outputs: assert property (
        @(posedge clk) rst |=> (!ack && !busy)
    ) else $error("ack or busy not low during reset");

endmodule

// ==== sim/amul_tb.sv ====
`timescale 1ns/1ps

`include "amul_config.svh"

module amul_tb;
    import amul_pkg::*;

    localparam int NUM_RANDOM  = 200;
    localparam int NUM_MEASURE = 64;
    localparam int NUM_PAIRS   = 16 + NUM_RANDOM;
    // a multiply costs an operand write, a status poll and a result read.
    localparam int NUM_TXN     = 40 + 6 * NUM_PAIRS + 3 * NUM_MEASURE;
    localparam logic [15:0] SEED = 16'd2501;

    logic        clk = 1'b0;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] dat_w;
    logic [3:0]  sel;
    logic [31:0] dat_r;
    logic        ack;

    logic [15:0] lfsr_state;
    logic [31:0] exp_count;
    abs_err_t    exp_sum;
    abs_err_t    exp_max;
    operand_t    corners [4];

    amul_top dut (.*);

    bind amul_wb_regs amul_properties u_props (
        .clk  (clk),
        .rst  (rst),
        .cyc  (cyc),
        .stb  (stb),
        .ack  (ack),
        .busy (busy)
    );

    always #2 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic operand_t rand_operand();
        operand_t v;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v[i] = lfsr_state[0];
        end
        return v;
    endfunction

    function automatic product_t ref_exact(input operand_t x, input operand_t y);
        return product_t'(x) * product_t'(y);
    endfunction

    // rows 0 to 5 survive only as the pruned gate pairs, counted per column.
    function automatic product_t ref_approx(input operand_t x, input operand_t y);
        logic        p [16][16];
        int          col [21];
        logic [63:0] sum;
        for (int i = 0; i < 16; i++) begin
            for (int j = 0; j < 16; j++) begin
                // a term is inverted when exactly one of its two bits is a sign bit.
                p[i][j] = (x[i] & y[j]) ^ ((i == 15) != (j == 15));
            end
        end
        col = '{default: 0};
        col[0]  = int'(p[0][0]);
        col[1]  = int'(p[0][1] ^ p[1][0]);
        col[2]  = int'(p[0][2] ^ p[1][1]);
        col[4]  = int'(p[2][1] & p[3][0]);
        col[5]  = int'(p[0][4] & p[1][3]);
        col[6]  = int'(p[2][4] ^ p[3][3]);
        col[7]  = int'(p[0][7] ^ p[1][6]);
        col[8]  = int'(p[4][4] ^ p[5][3]);
        col[9]  = int'(p[0][9] ^ p[1][8]) + int'(p[4][5] ^ p[5][4]);
        col[10] = int'(p[2][8] ^ p[3][7]) + int'(p[4][6] ^ p[5][5]);
        col[15] = int'(p[0][14] & p[1][13]) + int'(p[4][11] ^ p[5][10]);
        col[16] = int'(p[2][14] | p[3][13]);
        // column 17 carries a fixed one.
        col[17] = 1 + int'(p[2][15] ^ p[3][14]) + int'(p[4][12] | p[5][11])
                + int'(p[4][13] ^ p[5][12]);
        col[18] = int'(p[2][15] & p[3][14]) + int'(p[3][15]) + int'(p[4][13] | p[5][12]);
        col[19] = int'(p[4][14] & p[5][13]) + int'(p[4][15] ^ p[5][14]);
        col[20] = int'(p[4][15] & p[5][14]) + int'(p[5][15]);
        sum = 64'h8000_0000;
        for (int k = 0; k < 21; k++)
            sum = sum + (64'(col[k]) << k);
        for (int i = 6; i < 16; i++)
            for (int j = 0; j < 16; j++)
                sum = sum + (64'(p[i][j]) << (i + j));
        return sum[31:0];
    endfunction

    function automatic abs_err_t ref_abs_err(input product_t e, input product_t a);
        longint d;
        d = longint'(e) - longint'(a);
        return abs_err_t'(d < 0 ? -d : d);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_product(input string name, input product_t want, input product_t got);
        if (got !== want)
            abort_run($sformatf("[ERROR] t=%0t %s expected %0d got %0d",
                                $time, name, want, got));
    endtask

    task automatic check_err(input string name, input abs_err_t want, input abs_err_t got);
        if (got !== want)
            abort_run($sformatf("[ERROR] t=%0t %s expected %0d got %0d",
                                $time, name, want, got));
    endtask

    task automatic check_word(input string name, input logic [31:0] want,
                              input logic [31:0] got);
        if (got !== want)
            abort_run($sformatf("[ERROR] t=%0t %s expected 0x%08h got 0x%08h",
                                $time, name, want, got));
    endtask

    // one Wishbone classic single transfer, held until ack is seen.
    task automatic bus_cycle(input logic write, input logic [2:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= addr;
        dat_w <= wdata;
        sel   <= 4'hf;
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        rdata = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_cycle(1'b1, addr, data, ignored);
    endtask

    task automatic wb_read(input logic [2:0] addr, output logic [31:0] data);
        bus_cycle(1'b0, addr, 32'd0, data);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        wb_read(`AMUL_ADDR_STATUS, status);
        while (status[0])
            wb_read(`AMUL_ADDR_STATUS, status);
    endtask

    // keeps the expected statistics in step with one launched sample.
    task automatic track_sample(input amul_mode_e mode, input operand_t x, input operand_t y);
        abs_err_t    e;
        logic [32:0] total;
        if (mode == op_measure) begin
            e = ref_abs_err(ref_exact(x, y), ref_approx(x, y));
            total = {1'b0, exp_sum} + {1'b0, e};
            exp_sum = total[32] ? 32'hffff_ffff : total[31:0];
            if (e > exp_max)
                exp_max = e;
            exp_count = exp_count + 32'd1;
        end
    endtask

    // launches a multiply.
    task automatic write_operands(input amul_mode_e mode, input operand_t x, input operand_t y);
        wb_write(`AMUL_ADDR_OPERANDS, {y, x});
        track_sample(mode, x, y);
    endtask

    // two operand writes with cyc and stb held, so the second one lands
    // while the first sample is still in the pipeline.
    task automatic launch_pair(input operand_t x0, input operand_t y0,
                               input operand_t x1, input operand_t y1);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= `AMUL_ADDR_OPERANDS;
        dat_w <= {y0, x0};
        sel   <= 4'hf;
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        @(posedge clk);
        dat_w <= {y1, x1};
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        track_sample(op_measure, x0, y0);
        track_sample(op_measure, x1, y1);
    endtask

    task automatic multiply_check(input amul_mode_e mode, input operand_t x, input operand_t y);
        logic [31:0] word;
        write_operands(mode, x, y);
        wait_idle();
        wb_read(`AMUL_ADDR_RESULT, word);
        check_product("result", mode == op_exact ? ref_exact(x, y) : ref_approx(x, y), word);
    endtask

    task automatic check_stats();
        logic [31:0] word;
        wb_read(`AMUL_ADDR_COUNT, word);
        check_word("count", exp_count, word);
        wb_read(`AMUL_ADDR_ERR_SUM, word);
        check_err("err_sum", exp_sum, word);
        wb_read(`AMUL_ADDR_ERR_MAX, word);
        check_err("err_max", exp_max, word);
    endtask

    // corner pairs, then the same random pairs for every mode.
    task automatic sweep(input amul_mode_e mode);
        operand_t x;
        operand_t y;
        wb_write(`AMUL_ADDR_MODE, {30'b0, mode});
        for (int a = 0; a < 4; a++)
            for (int b = 0; b < 4; b++)
                multiply_check(mode, corners[a], corners[b]);
        lfsr_state = SEED;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            x = rand_operand();
            y = rand_operand();
            multiply_check(mode, x, y);
        end
    endtask

    initial begin
        logic [31:0] word;
        operand_t    x;
        operand_t    y;
        operand_t    px;
        operand_t    py;
        rst        = 1'b1;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;
        sel        = '0;
        lfsr_state = SEED;
        exp_count  = '0;
        exp_sum    = '0;
        exp_max    = '0;
        corners    = '{16'h0000, 16'hffff, 16'h8000, 16'h7fff};
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        wb_read(`AMUL_ADDR_MODE, word);
        check_word("mode", {30'b0, op_exact}, word);
        wb_read(`AMUL_ADDR_STATUS, word);
        check_word("status", 32'd0, word);
        check_stats();

        sweep(op_exact);
        sweep(op_approx);
        check_stats();

        wb_write(`AMUL_ADDR_MODE, {30'b0, op_measure});
        for (int n = 0; n < NUM_MEASURE; n++) begin
            x = rand_operand();
            y = rand_operand();
            multiply_check(op_measure, x, y);
        end
        check_stats();

        // the second launch follows the first with no status poll.
        px = rand_operand();
        py = rand_operand();
        x  = rand_operand();
        y  = rand_operand();
        launch_pair(px, py, x, y);
        wait_idle();
        wb_read(`AMUL_ADDR_RESULT, word);
        check_product("result", ref_approx(x, y), word);
        check_stats();

        wb_write(`AMUL_ADDR_COUNT, 32'd0);
        exp_count = '0;
        exp_sum   = '0;
        exp_max   = '0;
        check_stats();

        $display("Test OK");
        $finish;
    end

    initial begin
        #(NUM_TXN * 200);
        abort_run("timeout: the bus transactions did not complete within the time limit");
    end

endmodule
